//--- Makefile
TOP = tb_riscv_mdu

.PHONY: sim clean

sim:
	verilator --binary --assert -Wno-fatal --top-module $(TOP) -f files.f -o $(TOP)
	./obj_dir/$(TOP) | tee sim.log
	grep -q "TEST RESULT: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- files.f
riscv_mdu_pkg.sv
riscv_multiplier.sv
riscv_divider.sv
riscv_mdu.sv
tb_riscv_mdu.sv

//--- riscv_divider.sv
`timescale 1ns/1ps

module riscv_divider (
  input  logic                      i_riscv_mul_clk,
  input  logic                      i_riscv_mul_rst,
  input  riscv_mdu_pkg::xlen_t      i_riscv_div_rs1data,
  input  riscv_mdu_pkg::xlen_t      i_riscv_div_rs2data,
  input  riscv_mdu_pkg::mdu_ctrl_t  i_riscv_div_divctrl,
  output riscv_mdu_pkg::xlen_t      o_riscv_div_result,
  output logic                      o_riscv_div_valid
);

  riscv_mdu_pkg::div_state_e state;
  riscv_mdu_pkg::iter_cnt_t  count;
  riscv_mdu_pkg::xlen_t      rem;
  riscv_mdu_pkg::xlen_t      quo;                        // Dividend shifts out, quotient in
  riscv_mdu_pkg::xlen_t      dvsr;
  riscv_mdu_pkg::xlen_t      rs1_abs;
  riscv_mdu_pkg::xlen_t      rs2_abs;
  riscv_mdu_pkg::xlen_ext_t  shifted;
  riscv_mdu_pkg::xlen_ext_t  trial;
  logic                      q_neg;
  logic                      r_neg;
  logic                      is_signed;
  logic                      rem_sel;
  logic                      div_zero;
  logic                      ovf;
  logic                      start;
  logic                      step;
  logic                      fix;
  logic                      done;

  always_comb
  begin
    is_signed = 1'b0;
    rem_sel   = 1'b0;
    case (i_riscv_div_divctrl)
      riscv_mdu_pkg::DIV_CTRL_DIV:  is_signed = 1'b1;
      riscv_mdu_pkg::DIV_CTRL_DIVU: is_signed = 1'b0;
      riscv_mdu_pkg::DIV_CTRL_REM:
      begin
        is_signed = 1'b1;
        rem_sel   = 1'b1;
      end
      riscv_mdu_pkg::DIV_CTRL_REMU: rem_sel = 1'b1;
      default:                      rem_sel = 1'b0;
    endcase
  end

  assign start = i_riscv_div_divctrl[2] && !o_riscv_div_valid;
  assign step  = (state == riscv_mdu_pkg::DIV_RUN) &&
                 (count < riscv_mdu_pkg::iter_cnt_t'(riscv_mdu_pkg::MDU_ITERS));
  assign fix   = (state == riscv_mdu_pkg::DIV_RUN) &&
                 (count == riscv_mdu_pkg::iter_cnt_t'(riscv_mdu_pkg::MDU_ITERS));
  assign done  = (count == riscv_mdu_pkg::iter_cnt_t'(riscv_mdu_pkg::MDU_ITERS + 1));

  assign rs1_abs = (is_signed && i_riscv_div_rs1data[riscv_mdu_pkg::XLEN-1]) ?
                   -i_riscv_div_rs1data : i_riscv_div_rs1data;
  assign rs2_abs = (is_signed && i_riscv_div_rs2data[riscv_mdu_pkg::XLEN-1]) ?
                   -i_riscv_div_rs2data : i_riscv_div_rs2data;

  assign div_zero = (i_riscv_div_rs2data == '0);
  assign ovf      = is_signed && (i_riscv_div_rs2data == '1) &&
                    (i_riscv_div_rs1data == {1'b1, {(riscv_mdu_pkg::XLEN-1){1'b0}}});

  // MSB of the trial difference is its sign since rem < dvsr before the shift
  assign shifted = {rem, quo[riscv_mdu_pkg::XLEN-1]};
  assign trial   = shifted - {1'b0, dvsr};

  always_ff @(posedge i_riscv_mul_clk)
  begin
    if (state == riscv_mdu_pkg::DIV_IDLE && start)
    begin
      rem   <= '0;
      quo   <= rs1_abs;
      dvsr  <= rs2_abs;
      q_neg <= is_signed && (i_riscv_div_rs1data[riscv_mdu_pkg::XLEN-1] ^
                             i_riscv_div_rs2data[riscv_mdu_pkg::XLEN-1]);
      r_neg <= is_signed && i_riscv_div_rs1data[riscv_mdu_pkg::XLEN-1];
    end
    else if (step)
    begin
      if (!trial[riscv_mdu_pkg::XLEN])
      begin
        rem <= trial[riscv_mdu_pkg::XLEN-1:0];           // Keep difference
        quo <= {quo[riscv_mdu_pkg::XLEN-2:0], 1'b1};
      end
      else
      begin
        rem <= shifted[riscv_mdu_pkg::XLEN-1:0];         // Restore
        quo <= {quo[riscv_mdu_pkg::XLEN-2:0], 1'b0};
      end
    end
    else if (fix)
    begin
      if (div_zero)
      begin
        quo <= '1;
        rem <= i_riscv_div_rs1data;
      end
      else if (ovf)
      begin
        quo <= i_riscv_div_rs1data;
        rem <= '0;
      end
      else
      begin
        quo <= q_neg ? -quo : quo;
        rem <= r_neg ? -rem : rem;
      end
    end
  end

  always_ff @(posedge i_riscv_mul_clk or negedge i_riscv_mul_rst)
  begin
    if (!i_riscv_mul_rst)
    begin
      state              <= riscv_mdu_pkg::DIV_IDLE;
      count              <= '0;
      o_riscv_div_valid  <= 1'b0;
      o_riscv_div_result <= '0;
    end
    else
    begin
      case (state)
        riscv_mdu_pkg::DIV_IDLE:
        begin
          o_riscv_div_valid <= 1'b0;
          count             <= '0;
          if (start)
            state <= riscv_mdu_pkg::DIV_RUN;
        end
        riscv_mdu_pkg::DIV_RUN:
        begin
          if (done)
          begin
            o_riscv_div_valid  <= 1'b1;
            o_riscv_div_result <= rem_sel ? rem : quo;
            count              <= '0;
            state              <= riscv_mdu_pkg::DIV_IDLE;
          end
          else
            count <= count + 1'b1;                      // Counts steps and the sign fix-up
        end
        default: state <= riscv_mdu_pkg::DIV_IDLE;
      endcase
    end
  end

  a_div_valid_pulse: assert property (@(posedge i_riscv_mul_clk)
    disable iff (!i_riscv_mul_rst) o_riscv_div_valid |=> !o_riscv_div_valid)
    else $error("divider valid held for more than one cycle");

endmodule

//--- riscv_mdu.sv
`timescale 1ns/1ps

module riscv_mdu (
  input  logic                      i_riscv_mul_clk,
  input  logic                      i_riscv_mul_rst,
  input  riscv_mdu_pkg::xlen_t      i_riscv_mdu_rs1data,
  input  riscv_mdu_pkg::xlen_t      i_riscv_mdu_rs2data,
  input  riscv_mdu_pkg::mdu_ctrl_t  i_riscv_mdu_mulctrl,
  input  riscv_mdu_pkg::mdu_ctrl_t  i_riscv_mdu_divctrl,
  output riscv_mdu_pkg::xlen_t      o_riscv_mdu_result,
  output logic                      o_riscv_mdu_valid
);

  riscv_mdu_pkg::xlen_t mul_product;
  riscv_mdu_pkg::xlen_t div_result;
  logic                 mul_valid;
  logic                 div_valid;

  riscv_multiplier u_mul (
    .i_riscv_mul_clk     (i_riscv_mul_clk),
    .i_riscv_mul_rst     (i_riscv_mul_rst),
    .i_riscv_mul_rs1data (i_riscv_mdu_rs1data),
    .i_riscv_mul_rs2data (i_riscv_mdu_rs2data),
    .i_riscv_mul_mulctrl (i_riscv_mdu_mulctrl),
    .o_riscv_mul_product (mul_product),
    .o_riscv_mul_valid   (mul_valid)
  );

  riscv_divider u_div (
    .i_riscv_mul_clk     (i_riscv_mul_clk),
    .i_riscv_mul_rst     (i_riscv_mul_rst),
    .i_riscv_div_rs1data (i_riscv_mdu_rs1data),
    .i_riscv_div_rs2data (i_riscv_mdu_rs2data),
    .i_riscv_div_divctrl (i_riscv_mdu_divctrl),
    .o_riscv_div_result  (div_result),
    .o_riscv_div_valid   (div_valid)
  );

  // Only one engine completes in a cycle
  assign o_riscv_mdu_result = mul_valid ? mul_product : div_result;
  assign o_riscv_mdu_valid  = mul_valid | div_valid;

  a_one_valid: assert property (@(posedge i_riscv_mul_clk)
    disable iff (!i_riscv_mul_rst) !(mul_valid && div_valid))
    else $error("multiplier and divider completed in the same cycle");

  a_one_start: assert property (@(posedge i_riscv_mul_clk)
    disable iff (!i_riscv_mul_rst)
    !(i_riscv_mdu_mulctrl[2] && i_riscv_mdu_divctrl[2]))
    else $error("multiply and divide requested together");

endmodule

//--- riscv_mdu_pkg.sv
package riscv_mdu_pkg;

  localparam int XLEN      = 64;
  localparam int MDU_ITERS = 64;

  typedef logic [XLEN-1:0] xlen_t;
  typedef logic [XLEN:0]   xlen_ext_t;                   // One extension bit
  typedef logic [2:0]      mdu_ctrl_t;                   // Bit 2 requests a start
  typedef logic [6:0]      iter_cnt_t;

  // Multiplier control words
  localparam mdu_ctrl_t MUL_CTRL_MUL    = 3'b100;
  localparam mdu_ctrl_t MUL_CTRL_MULH   = 3'b101;
  localparam mdu_ctrl_t MUL_CTRL_MULHU  = 3'b110;
  localparam mdu_ctrl_t MUL_CTRL_MULHSU = 3'b111;

  // Divider control words
  localparam mdu_ctrl_t DIV_CTRL_DIV    = 3'b100;
  localparam mdu_ctrl_t DIV_CTRL_DIVU   = 3'b101;
  localparam mdu_ctrl_t DIV_CTRL_REM    = 3'b110;
  localparam mdu_ctrl_t DIV_CTRL_REMU   = 3'b111;

  typedef enum logic {
    MUL_IDLE,
    MUL_RUN
  } mul_state_e;

  typedef enum logic {
    DIV_IDLE,
    DIV_RUN
  } div_state_e;

endpackage

//--- riscv_mdu_stim.txt
# engine(M/D) ctrl(binary) rs1(hex) rs2(hex) expected(hex)
# M ctrl 100 MUL 101 MULH 110 MULHU 111 MULHSU, D ctrl 100 DIV 101 DIVU 110 REM 111 REMU
M 100 0000000000000007 0000000000000006 000000000000002a
D 100 0000000000000014 0000000000000006 0000000000000003
M 100 fffffffffffffffd 0000000000000005 fffffffffffffff1
D 110 ffffffffffffffec 0000000000000006 fffffffffffffffe
M 101 fffffffffffffffd 0000000000000005 ffffffffffffffff
D 100 0000000000000014 fffffffffffffffa fffffffffffffffd
M 110 ffffffffffffffff ffffffffffffffff fffffffffffffffe
D 110 ffffffffffffffec fffffffffffffffa fffffffffffffffe
M 100 ffffffffffffffff ffffffffffffffff 0000000000000001
D 101 ffffffffffffffec 0000000000000006 2aaaaaaaaaaaaaa7
M 111 ffffffffffffffff ffffffffffffffff ffffffffffffffff
D 111 ffffffffffffffec 0000000000000006 0000000000000002
M 101 8000000000000000 8000000000000000 4000000000000000
D 100 0000000000000007 0000000000000000 ffffffffffffffff
M 111 8000000000000000 8000000000000000 c000000000000000
D 110 fffffffffffffff9 0000000000000000 fffffffffffffff9
M 100 0000000000000000 123456789abcdef0 0000000000000000
D 101 0000000000000007 0000000000000000 ffffffffffffffff
M 100 0000000000000001 123456789abcdef0 123456789abcdef0
D 111 0000000000000007 0000000000000000 0000000000000007
M 101 0000000100000000 0000000100000000 0000000000000001
D 100 8000000000000000 ffffffffffffffff 8000000000000000
M 110 ffffffffffffffff 0000000000000002 0000000000000001
D 110 8000000000000000 ffffffffffffffff 0000000000000000
M 111 0000000000000002 ffffffffffffffff 0000000000000001
D 100 ffffffffffffffec fffffffffffffffa 0000000000000003
M 101 8000000000000000 ffffffffffffffff 0000000000000000
D 101 123456789abcdef0 0000000000000100 00123456789abcde

//--- riscv_multiplier.sv
`timescale 1ns/1ps

module riscv_multiplier (
  input  logic                      i_riscv_mul_clk,
  input  logic                      i_riscv_mul_rst,
  input  riscv_mdu_pkg::xlen_t      i_riscv_mul_rs1data,
  input  riscv_mdu_pkg::xlen_t      i_riscv_mul_rs2data,
  input  riscv_mdu_pkg::mdu_ctrl_t  i_riscv_mul_mulctrl,
  output riscv_mdu_pkg::xlen_t      o_riscv_mul_product,
  output logic                      o_riscv_mul_valid
);

  riscv_mdu_pkg::mul_state_e state;
  riscv_mdu_pkg::iter_cnt_t  count;
  riscv_mdu_pkg::xlen_ext_t  mcand;                      // Multiplicand
  riscv_mdu_pkg::xlen_ext_t  mplier;                     // Multiplier
  riscv_mdu_pkg::xlen_ext_t  acc_hi;                     // Partial product
  riscv_mdu_pkg::xlen_ext_t  acc_lo;                     // Shifted multiplier, low product
  riscv_mdu_pkg::xlen_ext_t  partial;
  riscv_mdu_pkg::xlen_t      prod_sel;
  logic                      q_m1;                       // Booth bit Q-1
  logic                      start;
  logic                      done;

  // Valid high blocks a restart while the issuer still holds the word
  assign start = i_riscv_mul_mulctrl[2] && !o_riscv_mul_valid;
  assign done  = (count == riscv_mdu_pkg::iter_cnt_t'(riscv_mdu_pkg::MDU_ITERS + 1));

  always_comb
  begin
    case (i_riscv_mul_mulctrl)
      riscv_mdu_pkg::MUL_CTRL_MULHU:
      begin
        mcand  = {1'b0, i_riscv_mul_rs1data};
        mplier = {1'b0, i_riscv_mul_rs2data};
      end
      riscv_mdu_pkg::MUL_CTRL_MULHSU:
      begin
        mcand  = {i_riscv_mul_rs1data[riscv_mdu_pkg::XLEN-1], i_riscv_mul_rs1data};
        mplier = {1'b0, i_riscv_mul_rs2data};
      end
      default:
      begin
        mcand  = {i_riscv_mul_rs1data[riscv_mdu_pkg::XLEN-1], i_riscv_mul_rs1data};
        mplier = {i_riscv_mul_rs2data[riscv_mdu_pkg::XLEN-1], i_riscv_mul_rs2data};
      end
    endcase
  end

  // Radix-2 Booth recoding of {Q0, Q-1}
  always_comb
  begin
    case ({acc_lo[0], q_m1})
      2'b10:   partial = acc_hi - mcand;
      2'b01:   partial = acc_hi + mcand;
      default: partial = acc_hi;
    endcase
  end

  always_comb
  begin
    case (i_riscv_mul_mulctrl)
      riscv_mdu_pkg::MUL_CTRL_MUL:
        prod_sel = acc_lo[riscv_mdu_pkg::XLEN-1:0];
      riscv_mdu_pkg::MUL_CTRL_MULH,
      riscv_mdu_pkg::MUL_CTRL_MULHU,
      riscv_mdu_pkg::MUL_CTRL_MULHSU:
        prod_sel = {acc_hi[riscv_mdu_pkg::XLEN-2:0], acc_lo[riscv_mdu_pkg::XLEN]};
      default:
        prod_sel = '0;
    endcase
  end

  always_ff @(posedge i_riscv_mul_clk)
  begin
    if (state == riscv_mdu_pkg::MUL_IDLE && start)
    begin
      acc_hi <= '0;
      acc_lo <= mplier;
      q_m1   <= 1'b0;
    end
    else if (state == riscv_mdu_pkg::MUL_RUN && !done)
    begin
      acc_hi <= {partial[riscv_mdu_pkg::XLEN], partial[riscv_mdu_pkg::XLEN:1]};
      acc_lo <= {partial[0], acc_lo[riscv_mdu_pkg::XLEN:1]};  // Arithmetic shift right
      q_m1   <= acc_lo[0];
    end
  end

  always_ff @(posedge i_riscv_mul_clk or negedge i_riscv_mul_rst)
  begin
    if (!i_riscv_mul_rst)
    begin
      state               <= riscv_mdu_pkg::MUL_IDLE;
      count               <= '0;
      o_riscv_mul_valid   <= 1'b0;
      o_riscv_mul_product <= '0;
    end
    else
    begin
      case (state)
        riscv_mdu_pkg::MUL_IDLE:
        begin
          o_riscv_mul_valid <= 1'b0;
          count             <= '0;
          if (start)
            state <= riscv_mdu_pkg::MUL_RUN;
        end
        riscv_mdu_pkg::MUL_RUN:
        begin
          if (done)
          begin
            o_riscv_mul_valid   <= 1'b1;
            o_riscv_mul_product <= prod_sel;
            count               <= '0;
            state               <= riscv_mdu_pkg::MUL_IDLE;
          end
          else
            count <= count + 1'b1;
        end
        default: state <= riscv_mdu_pkg::MUL_IDLE;
      endcase
    end
  end

  a_mul_valid_pulse: assert property (@(posedge i_riscv_mul_clk)
    disable iff (!i_riscv_mul_rst) o_riscv_mul_valid |=> !o_riscv_mul_valid)
    else $error("multiplier valid held for more than one cycle");

endmodule

//--- tb_riscv_mdu.sv
`timescale 1ns/1ps

module tb_riscv_mdu;

  localparam int CLK_HALF = 10;
  localparam int LATENCY  = riscv_mdu_pkg::MDU_ITERS + 2;  // Start edge to valid edge
  localparam int MAX_WAIT = LATENCY + 10;

  logic                     i_riscv_mul_clk;
  logic                     i_riscv_mul_rst;
  riscv_mdu_pkg::xlen_t     i_riscv_mdu_rs1data;
  riscv_mdu_pkg::xlen_t     i_riscv_mdu_rs2data;
  riscv_mdu_pkg::mdu_ctrl_t i_riscv_mdu_mulctrl;
  riscv_mdu_pkg::mdu_ctrl_t i_riscv_mdu_divctrl;
  riscv_mdu_pkg::xlen_t     o_riscv_mdu_result;
  logic                     o_riscv_mdu_valid;

  byte                      q_sel[$];                     // M or D
  riscv_mdu_pkg::mdu_ctrl_t q_ctrl[$];
  riscv_mdu_pkg::xlen_t     q_rs1[$];
  riscv_mdu_pkg::xlen_t     q_rs2[$];
  riscv_mdu_pkg::xlen_t     q_exp[$];

  riscv_mdu_pkg::xlen_t     last_div_result = '0;         // Top result between pulses
  int                       cycle           = 0;
  int                       n_ops           = 0;
  int                       ops_issued      = 0;
  int                       pulses_seen     = 0;
  int                       result_errors   = 0;
  int                       valid_errors    = 0;
  int                       other_errors    = 0;
  logic                     loaded          = 1'b0;

  riscv_mdu dut (
    .i_riscv_mul_clk     (i_riscv_mul_clk),
    .i_riscv_mul_rst     (i_riscv_mul_rst),
    .i_riscv_mdu_rs1data (i_riscv_mdu_rs1data),
    .i_riscv_mdu_rs2data (i_riscv_mdu_rs2data),
    .i_riscv_mdu_mulctrl (i_riscv_mdu_mulctrl),
    .i_riscv_mdu_divctrl (i_riscv_mdu_divctrl),
    .o_riscv_mdu_result  (o_riscv_mdu_result),
    .o_riscv_mdu_valid   (o_riscv_mdu_valid)
  );

  initial
  begin
    i_riscv_mul_clk = 1'b0;
    forever #CLK_HALF i_riscv_mul_clk = ~i_riscv_mul_clk;
  end

  always @(posedge i_riscv_mul_clk)
    cycle <= cycle + 1;                                   // Edge index read at falling edges

  task automatic check_result(input string name, input riscv_mdu_pkg::xlen_t actual,
                              input riscv_mdu_pkg::xlen_t expected);
    if (actual !== expected)
    begin
      $display("ERROR %s: got %h expected %h at %0t", name, actual, expected, $time);
      result_errors++;
    end
  endtask

  task automatic check_valid(input logic actual, input logic expected, input string where);
    if (actual !== expected)
    begin
      if (expected)
        $display("No valid pulse seen %s at %0t", where, $time);
      else
        $display("Unexpected valid pulse seen %s at %0t", where, $time);
      valid_errors++;
    end
  endtask

  task automatic idle_cycle();
    @(posedge i_riscv_mul_clk);
    i_riscv_mdu_mulctrl <= '0;
    i_riscv_mdu_divctrl <= '0;
    @(negedge i_riscv_mul_clk);
    check_valid(o_riscv_mdu_valid, 1'b0, "in an idle cycle");
    check_result("o_riscv_mdu_result", o_riscv_mdu_result, last_div_result);
  endtask

  task automatic run_op(input int idx);
    int   e0;
    int   waited;
    logic seen;
    @(posedge i_riscv_mul_clk);
    i_riscv_mdu_rs1data <= q_rs1[idx];
    i_riscv_mdu_rs2data <= q_rs2[idx];
    if (q_sel[idx] == "M")
    begin
      i_riscv_mdu_mulctrl <= q_ctrl[idx];
      i_riscv_mdu_divctrl <= '0;
    end
    else
    begin
      i_riscv_mdu_mulctrl <= '0;
      i_riscv_mdu_divctrl <= q_ctrl[idx];
    end
    ops_issued++;
    @(negedge i_riscv_mul_clk);
    e0 = cycle + 1;                                       // Engine samples the start next edge
    check_valid(o_riscv_mdu_valid, 1'b0, $sformatf("before start of operation %0d", idx));
    check_result("o_riscv_mdu_result", o_riscv_mdu_result, last_div_result);
    waited = 0;
    seen   = 1'b0;
    while (!seen && waited < MAX_WAIT)
    begin
      @(negedge i_riscv_mul_clk);
      waited++;
      if (o_riscv_mdu_valid)
        seen = 1'b1;
      else
        check_result("o_riscv_mdu_result", o_riscv_mdu_result, last_div_result);
    end
    if (!seen)
      check_valid(o_riscv_mdu_valid, 1'b1, $sformatf("for operation %0d", idx));
    else
    begin
      pulses_seen++;
      if (cycle - e0 != LATENCY)
      begin
        $display("Valid for operation %0d came %0d edges after the start edge, not %0d",
                 idx, cycle - e0, LATENCY);
        valid_errors++;
      end
      check_result("o_riscv_mdu_result", o_riscv_mdu_result, q_exp[idx]);
      if (q_sel[idx] == "D")
        last_div_result = q_exp[idx];
    end
  endtask

  initial
  begin : main
    int                       fd;
    int                       gap;
    string                    line;
    byte                      sel;
    riscv_mdu_pkg::mdu_ctrl_t ctrl;
    riscv_mdu_pkg::xlen_t     a;
    riscv_mdu_pkg::xlen_t     b;
    riscv_mdu_pkg::xlen_t     exp;
    i_riscv_mul_rst     = 1'b0;
    i_riscv_mdu_rs1data = '0;
    i_riscv_mdu_rs2data = '0;
    i_riscv_mdu_mulctrl = '0;
    i_riscv_mdu_divctrl = '0;
    void'($urandom(82967));
    fd = $fopen("riscv_mdu_stim.txt", "r");
    if (fd == 0)
    begin
      $display("Could not open the stimulus file riscv_mdu_stim.txt");
      other_errors++;
    end
    else
    begin
      while (!$feof(fd))
      begin
        line = "";
        if ($fgets(line, fd) != 0)
        begin
          if (line.len() > 0 && line[0] != "#")
          begin
            if ($sscanf(line, "%c %b %h %h %h", sel, ctrl, a, b, exp) == 5)
            begin
              q_sel.push_back(sel);
              q_ctrl.push_back(ctrl);
              q_rs1.push_back(a);
              q_rs2.push_back(b);
              q_exp.push_back(exp);
            end
          end
        end
      end
      $fclose(fd);
    end
    n_ops = q_sel.size();
    if (n_ops == 0)
    begin
      $display("The stimulus file gave no operations");
      other_errors++;
    end
    loaded = 1'b1;
    repeat (2) @(posedge i_riscv_mul_clk);
    i_riscv_mul_rst <= 1'b1;
    repeat (3) idle_cycle();                              // Reset state has no valid and zero result
    for (int i = 0; i < n_ops; i++)
    begin
      gap = (i % 4 == 3) ? 0 : int'($urandom % 6);        // Every fourth start is back to back
      repeat (gap) idle_cycle();
      run_op(i);
    end
    repeat (3) idle_cycle();
    $display("Counts: %0d ops, %0d pulses, %0d result errors, %0d valid errors, %0d other errors",
             ops_issued, pulses_seen, result_errors, valid_errors, other_errors);
    if (result_errors == 0 && valid_errors == 0 && other_errors == 0 &&
        pulses_seen == ops_issued)
      $display("TEST RESULT: PASS");
    else
      $display("TEST RESULT: FAIL");
    $finish;
  end

  initial
  begin : watchdog
    wait (loaded);
    repeat (n_ops * 80 + 100) @(posedge i_riscv_mul_clk);
    $display("Watchdog expired after %0d cycles, the run did not finish", n_ops * 80 + 100);
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule
